// ==== hdl/boot_fetch_pkg.sv ====
// shared widths and types of the boot fetch path, imported by every block in it
package boot_fetch_pkg;

	// ========================================
	// address and line geometry
	// ========================================

	// low byte-offset bits dropped to form a line index
	localparam int LINE_OFFSET_W = 4;

	// full byte address into the boot space
	localparam int BYTE_ADDR_W = 18;

	// line number width, byte address minus its offset bits
	localparam int LINE_IDX_W = BYTE_ADDR_W - LINE_OFFSET_W;

	// one rom line
	localparam int LINE_W = 128;

	// ========================================
	// types
	// ========================================

	typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;

	typedef logic [LINE_IDX_W-1:0] line_idx_t;

	typedef logic [LINE_W-1:0] line_t;

endpackage

// ==== hdl/boot_rom.sv ====
// on-chip boot rom with registered address and data stages, acked on the third clock
`timescale 1ns/100ps

module boot_rom import boot_fetch_pkg::*; #(
	parameter int ROM_LINES = 32
) (
	input  logic       clk_i,
	input  logic       reset_i,
	input  logic       cs_i,
	input  logic       cyc_i,
	input  logic       stb_i,
	input  byte_addr_t adr_i,
	output logic       ack_o,
	output line_t      dat_o
);

	// image loaded at elaboration, one hex line per entry
	localparam string ROM_FILE = "hdl/boot_rom.mem";

	line_t     rom_mem [ROM_LINES];
	line_idx_t radr_q;
	line_t     dat_q;
	logic      sel;
	logic      rdy1_q;
	logic      rdy_q;

	initial $readmemh(ROM_FILE, rom_mem);

	// select needs all three strobes
	assign sel = cs_i && cyc_i && stb_i;

	// ready chain, any cycle with select low clears it
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			rdy1_q <= 1'b0;
			rdy_q <= 1'b0;
			ack_o <= 1'b0;
		end else begin
			rdy1_q <= sel;
			rdy_q <= rdy1_q & sel;
			ack_o <= sel ? rdy_q : 1'b0;
		end
	end

	// stage 1: line index, stage 2: array read, stage 3: output
	// index wraps inside the array, range checks live in the master
	always_ff @(posedge clk_i) begin
		radr_q <= adr_i[BYTE_ADDR_W-1:LINE_OFFSET_W];
		dat_q <= rom_mem[radr_q % ROM_LINES];
		dat_o <= dat_q;
	end

	// the registered index must match the address that gets the ack
	a_adr_steady: assert property (@(posedge clk_i) disable iff (reset_i)
		sel && !ack_o |=> !sel || $stable(adr_i));

endmodule

// ==== hdl/fetch_addr_queue.sv ====
// credit-controlled queue of requested byte addresses feeding the rom bus master
`timescale 1ns/100ps

module fetch_addr_queue import boot_fetch_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic       clk_i,
	input  logic       reset_i,
	input  logic       addr_valid_i,
	input  byte_addr_t addr_i,
	output logic       req_credit_o,
	output logic       head_valid_o,
	output byte_addr_t head_addr_o,
	input  logic       pop_i
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(QUEUE_DEPTH - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(QUEUE_DEPTH);

	byte_addr_t       slot_mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;

	// ========================================
	// storage
	// ========================================

	// no full check, the requester only pushes on a held credit
	always_ff @(posedge clk_i) begin
		if (addr_valid_i)
			slot_mem[wr_ptr_q] <= addr_i;
	end

	assign head_valid_o = (count_q != '0);
	assign head_addr_o = slot_mem[rd_ptr_q];

	// ========================================
	// pointers, count and credit return
	// ========================================

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			req_credit_o <= 1'b0;
		end else begin
			// pointers wrap at the depth, so any depth works
			if (addr_valid_i)
				wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
			if (pop_i)
				rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
			case ({addr_valid_i, pop_i})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			// a freed slot goes straight back to the requester
			req_credit_o <= pop_i;
		end
	end

	a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
		addr_valid_i |-> count_q != CNT_FULL);

	a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
		pop_i |-> head_valid_o);

endmodule

// ==== hdl/rom_bus_master.sv ====
// single-cycle wishbone classic master, one rom read per queued address
`timescale 1ns/100ps

module rom_bus_master import boot_fetch_pkg::*; #(
	parameter int ROM_LINES = 32
) (
	input  logic       clk_i,
	input  logic       reset_i,
	input  logic       head_valid_i,
	input  byte_addr_t head_addr_i,
	output logic       pop_o,
	output logic       cyc_o,
	output logic       stb_o,
	output logic       cs_o,
	output byte_addr_t adr_o,
	input  logic       ack_i,
	input  line_t      dat_i,
	output logic       ln_valid_o,
	output line_t      ln_data_o,
	output logic       ln_err_o,
	input  logic       ln_ready_i
);

	localparam line_idx_t LINE_LIMIT = line_idx_t'(ROM_LINES);

	// gap lets the rom ready chain drain before the next select
	typedef enum logic [1:0] {
		st_idle,
		st_bus,
		st_hold,
		st_gap
	} bus_state_t;

	bus_state_t state_q;
	byte_addr_t addr_q;
	line_t      line_q;
	logic       err_q;
	line_idx_t  head_idx;
	logic       in_range;
	logic       take;

	assign head_idx = head_addr_i[BYTE_ADDR_W-1:LINE_OFFSET_W];
	assign in_range = (head_idx < LINE_LIMIT);
	assign take = (state_q == st_idle) && head_valid_i;

	// ========================================
	// state machine
	// ========================================

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= st_idle;
			err_q <= 1'b0;
		end else begin
			case (state_q)
				st_idle: begin
					if (head_valid_i) begin
						// out of range skips the bus entirely
						err_q <= !in_range;
						state_q <= in_range ? st_bus : st_hold;
					end
				end
				st_bus: if (ack_i) state_q <= st_hold;
				// ack may still be high on entry, it is ignored here
				st_hold: if (ln_ready_i) state_q <= st_gap;
				st_gap: state_q <= st_idle;
				default: state_q <= st_idle;
			endcase
		end
	end

	// address and line payload
	always_ff @(posedge clk_i) begin
		if (take) begin
			addr_q <= head_addr_i;
			line_q <= '0;
		end else if (state_q == st_bus && ack_i) begin
			line_q <= dat_i;
		end
	end

	assign pop_o = take;
	assign cyc_o = (state_q == st_bus);
	assign stb_o = cyc_o;
	assign cs_o = cyc_o;
	assign adr_o = addr_q;
	assign ln_valid_o = (state_q == st_hold);
	assign ln_data_o = line_q;
	assign ln_err_o = err_q;

	// rom ack is registered, so it may trail the cycle by one clock
	a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
		ack_i |-> $past(cyc_o));

endmodule

// ==== hdl/line_out_buffer.sv ====
// output line fifo that releases one line per consumer credit
`timescale 1ns/100ps

module line_out_buffer import boot_fetch_pkg::*; #(
	parameter int OUT_DEPTH = 2,
	parameter int OUT_CREDITS = 2
) (
	input  logic  clk_i,
	input  logic  reset_i,
	input  logic  ln_valid_i,
	input  line_t ln_data_i,
	input  logic  ln_err_i,
	output logic  ln_ready_o,
	input  logic  line_credit_i,
	output logic  line_valid_o,
	output line_t line_o,
	output logic  line_err_o
);

	localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
	localparam int CNT_W = $clog2(OUT_DEPTH + 1);
	localparam int CRED_W = $clog2(OUT_CREDITS + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(OUT_DEPTH - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(OUT_DEPTH);
	localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(OUT_CREDITS);

	line_t             line_mem [OUT_DEPTH];
	logic              err_mem [OUT_DEPTH];
	logic [PTR_W-1:0]  wr_ptr_q;
	logic [PTR_W-1:0]  rd_ptr_q;
	logic [CNT_W-1:0]  count_q;
	logic [CRED_W-1:0] credits_q;
	logic              push;
	logic              send;

	assign ln_ready_o = (count_q != CNT_FULL);
	assign push = ln_valid_i && ln_ready_o;
	// head leaves only with a credit in hand
	assign send = (count_q != '0) && (credits_q != '0);

	always_ff @(posedge clk_i) begin
		if (push) begin
			line_mem[wr_ptr_q] <= ln_data_i;
			err_mem[wr_ptr_q] <= ln_err_i;
		end
		if (send)
			line_o <= line_mem[rd_ptr_q];
	end

	// ========================================
	// pointers, count, credits
	// ========================================

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			credits_q <= CRED_MAX;
			line_valid_o <= 1'b0;
			line_err_o <= 1'b0;
		end else begin
			if (push)
				wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
			if (send)
				rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
			count_q <= count_q + CNT_W'(push) - CNT_W'(send);
			// returned credit and spent credit may land together
			credits_q <= credits_q + CRED_W'(line_credit_i) - CRED_W'(send);
			line_valid_o <= send;
			line_err_o <= send ? err_mem[rd_ptr_q] : 1'b0;
		end
	end

	a_credit_max: assert property (@(posedge clk_i) disable iff (reset_i)
		credits_q <= CRED_MAX);

endmodule

// ==== hdl/boot_fetch.sv ====
// boot fetch top level: address queue, rom bus master, line buffer and boot rom
`timescale 1ns/100ps

module boot_fetch import boot_fetch_pkg::*; #(
	parameter int ROM_LINES = 32,
	parameter int QUEUE_DEPTH = 4,
	parameter int OUT_DEPTH = 2,
	parameter int OUT_CREDITS = 2
) (
	input  logic       clk_i,
	input  logic       reset_i,
	input  logic       addr_valid_i,
	input  byte_addr_t addr_i,
	output logic       req_credit_o,
	input  logic       line_credit_i,
	output logic       line_valid_o,
	output line_t      line_o,
	output logic       line_err_o
);

	// queue to master
	logic       q_valid;
	byte_addr_t q_addr;
	logic       q_pop;
	// master to rom, wishbone classic
	logic       rom_cyc;
	logic       rom_stb;
	logic       rom_cs;
	byte_addr_t rom_adr;
	logic       rom_ack;
	line_t      rom_dat;
	// master to buffer
	logic       ln_valid;
	line_t      ln_data;
	logic       ln_err;
	logic       ln_ready;

	fetch_addr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) fetch_addr_queue_i (
		.clk_i(clk_i), .reset_i(reset_i),
		.addr_valid_i(addr_valid_i), .addr_i(addr_i), .req_credit_o(req_credit_o),
		.head_valid_o(q_valid), .head_addr_o(q_addr), .pop_i(q_pop)
	);

	rom_bus_master #(.ROM_LINES(ROM_LINES)) rom_bus_master_i (
		.clk_i(clk_i), .reset_i(reset_i),
		.head_valid_i(q_valid), .head_addr_i(q_addr), .pop_o(q_pop),
		.cyc_o(rom_cyc), .stb_o(rom_stb), .cs_o(rom_cs), .adr_o(rom_adr),
		.ack_i(rom_ack), .dat_i(rom_dat),
		.ln_valid_o(ln_valid), .ln_data_o(ln_data), .ln_err_o(ln_err),
		.ln_ready_i(ln_ready)
	);

	line_out_buffer #(.OUT_DEPTH(OUT_DEPTH), .OUT_CREDITS(OUT_CREDITS)) line_out_buffer_i (
		.clk_i(clk_i), .reset_i(reset_i),
		.ln_valid_i(ln_valid), .ln_data_i(ln_data), .ln_err_i(ln_err), .ln_ready_o(ln_ready),
		.line_credit_i(line_credit_i), .line_valid_o(line_valid_o),
		.line_o(line_o), .line_err_o(line_err_o)
	);

	boot_rom #(.ROM_LINES(ROM_LINES)) boot_rom_i (
		.clk_i(clk_i), .reset_i(reset_i),
		.cs_i(rom_cs), .cyc_i(rom_cyc), .stb_i(rom_stb), .adr_i(rom_adr),
		.ack_o(rom_ack), .dat_o(rom_dat)
	);

endmodule

// ==== test/boot_fetch_tb.sv ====
// directed testbench for boot_fetch, run from the project root so the rom image path resolves
`timescale 1ns/100ps

module boot_fetch_tb import boot_fetch_pkg::*; ();

	localparam int ROM_LINES = 32;
	localparam int QUEUE_DEPTH = 4;
	localparam int OUT_DEPTH = 2;
	localparam int OUT_CREDITS = 2;
	// longest test is well under a thousand cycles
	localparam int MAX_CYCLES = 20000;
	localparam int QUIET_CYCLES = 40;

	logic       clk_i;
	logic       reset_i;
	logic       addr_valid_i;
	byte_addr_t addr_i;
	logic       req_credit_o;
	logic       line_credit_i;
	logic       line_valid_o;
	line_t      line_o;
	logic       line_err_o;

	// reference copy of the rom image
	line_t image [ROM_LINES];

	line_t rx_line [$];
	logic  rx_err [$];
	line_t exp_line [$];
	logic  exp_err [$];

	int     req_credits;
	int     cons_credits;
	int     pending_returns;
	int     credit_pulses;
	bit     auto_return;
	int     pass_count;
	int     err_count;
	int     cycle_count;
	integer seed;

	boot_fetch #(
		.ROM_LINES(ROM_LINES),
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.OUT_DEPTH(OUT_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) boot_fetch_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.addr_valid_i(addr_valid_i),
		.addr_i(addr_i),
		.req_credit_o(req_credit_o),
		.line_credit_i(line_credit_i),
		.line_valid_o(line_valid_o),
		.line_o(line_o),
		.line_err_o(line_err_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// ========================================
	// monitor and consumer credit return
	// ========================================

	// sampled mid-cycle, away from the rising edge
	always @(negedge clk_i) begin
		if (!reset_i) begin
			if (req_credit_o) begin
				req_credits++;
				credit_pulses++;
			end
			if (line_valid_o) begin
				if (cons_credits == 0) begin
					$display("at %0t: line delivered while no consumer credit was held", $time);
					err_count++;
				end
				cons_credits--;
				rx_line.push_back(line_o);
				rx_err.push_back(line_err_o);
				if (auto_return)
					pending_returns++;
			end
		end
	end

	// one credit pulse per cycle while returns are pending
	always @(posedge clk_i) begin
		#2;
		if (pending_returns > 0) begin
			line_credit_i = 1'b1;
			pending_returns--;
			cons_credits++;
		end else begin
			line_credit_i = 1'b0;
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk_i);
			cycle_count++;
		end
		$display("timeout: the run did not end within %0d clock cycles", MAX_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	// ========================================
	// helpers
	// ========================================

	task automatic check_val(input line_t got, input line_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
			err_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_i);
		#2;
	endtask

	// push one address on a held credit and predict its line
	task automatic send_addr(input byte_addr_t a);
		int n;
		n = int'(a[BYTE_ADDR_W-1:LINE_OFFSET_W]);
		while (req_credits == 0)
			next_cycle();
		addr_valid_i = 1'b1;
		addr_i = a;
		req_credits--;
		if (n >= ROM_LINES) begin
			exp_line.push_back('0);
			exp_err.push_back(1'b1);
		end else begin
			exp_line.push_back(image[n]);
			exp_err.push_back(1'b0);
		end
		next_cycle();
		addr_valid_i = 1'b0;
	endtask

	// queue one consumer credit for the return process to drive
	task automatic give_credit();
		@(negedge clk_i);
		pending_returns++;
	endtask

	task automatic compare_lines(input string name);
		int i;
		i = 0;
		while (rx_line.size() < exp_line.size())
			next_cycle();
		// a late extra line would land in this quiet window
		repeat (QUIET_CYCLES) next_cycle();
		if (rx_line.size() != exp_line.size()) begin
			$display("at %0t: %s received %0d lines where %0d were requested",
				$time, name, rx_line.size(), exp_line.size());
			err_count++;
		end
		while (exp_line.size() > 0 && rx_line.size() > 0) begin
			check_val(rx_line.pop_front(), exp_line.pop_front(),
				$sformatf("%s line %0d data", name, i));
			check_val(line_t'(rx_err.pop_front()), line_t'(exp_err.pop_front()),
				$sformatf("%s line %0d error flag", name, i));
			i++;
		end
		rx_line.delete();
		rx_err.delete();
		exp_line.delete();
		exp_err.delete();
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("test %s finished with %0d errors", name, err_count - errs_before);
	endtask

	// ========================================
	// tests
	// ========================================

	task automatic test_single_fetch();
		int errs_before;
		errs_before = err_count;
		credit_pulses = 0;
		next_cycle();
		// offset 7 inside line 5
		send_addr(byte_addr_t'(18'h057));
		compare_lines("single fetch");
		check_val(line_t'(credit_pulses), line_t'(1), "single fetch credit pulses");
		report_test("single fetch", errs_before);
	endtask

	task automatic test_queue_fill();
		int errs_before;
		errs_before = err_count;
		credit_pulses = 0;
		next_cycle();
		check_val(line_t'(req_credits), line_t'(QUEUE_DEPTH), "request credits before queue fill");
		send_addr(byte_addr_t'(18'h000));
		send_addr(byte_addr_t'(18'h1f8));
		send_addr(byte_addr_t'(18'h0c4));
		send_addr(byte_addr_t'(18'h07f));
		compare_lines("queue fill");
		check_val(line_t'(credit_pulses), line_t'(QUEUE_DEPTH), "queue fill credit pulses");
		report_test("queue fill", errs_before);
	endtask

	task automatic test_random_burst();
		int errs_before;
		int r;
		errs_before = err_count;
		next_cycle();
		for (int k = 0; k < 40; k++) begin
			r = $random(seed);
			send_addr(byte_addr_t'($unsigned(r) % (ROM_LINES << LINE_OFFSET_W)));
		end
		compare_lines("random burst");
		report_test("random burst", errs_before);
	endtask

	task automatic test_range_error();
		int errs_before;
		byte_addr_t addrs [7] = '{18'h010, 18'h200, 18'h1f0, 18'h3ffff,
			18'h0a5, 18'h12345, 18'h1ff};
		errs_before = err_count;
		next_cycle();
		foreach (addrs[k])
			send_addr(addrs[k]);
		compare_lines("range error");
		report_test("range error", errs_before);
	endtask

	task automatic test_back_pressure();
		int errs_before;
		errs_before = err_count;
		credit_pulses = 0;
		auto_return = 1'b0;
		next_cycle();
		for (int k = 0; k < 8; k++)
			send_addr(byte_addr_t'(k * 48 + 3));
		while (rx_line.size() < OUT_CREDITS)
			next_cycle();
		repeat (QUIET_CYCLES) next_cycle();
		check_val(line_t'(rx_line.size()), line_t'(OUT_CREDITS), "lines out while stalled");
		// two lines out, two in the buffer and one held in the master
		check_val(line_t'(credit_pulses), line_t'(OUT_CREDITS + OUT_DEPTH + 1),
			"request credits while stalled");
		for (int k = OUT_CREDITS; k < 8; k++) begin
			give_credit();
			while (rx_line.size() < k + 1)
				next_cycle();
		end
		compare_lines("back-pressure");
		check_val(line_t'(credit_pulses), line_t'(8), "back-pressure credit pulses");
		// top the consumer credits back up
		repeat (OUT_CREDITS) give_credit();
		auto_return = 1'b1;
		report_test("back-pressure", errs_before);
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		seed = 32'hf9fe;
		reset_i = 1'b1;
		addr_valid_i = 1'b0;
		addr_i = '0;
		line_credit_i = 1'b0;
		req_credits = QUEUE_DEPTH;
		cons_credits = OUT_CREDITS;
		pending_returns = 0;
		credit_pulses = 0;
		auto_return = 1'b1;
		pass_count = 0;
		err_count = 0;
		$readmemh("hdl/boot_rom.mem", image);
		// an unloaded image would make every predicted line unknown
		foreach (image[k]) begin
			if ($isunknown(image[k])) begin
				$display("rom image line %0d did not load from the image file", k);
				err_count++;
			end
		end
		repeat (16) @(posedge clk_i);
		#2;
		reset_i = 1'b0;
		check_val(line_t'(line_valid_o), '0, "line valid after reset");
		check_val(line_t'(line_err_o), '0, "line error after reset");
		check_val(line_t'(req_credit_o), '0, "request credit after reset");

		test_single_fetch();
		test_queue_fill();
		test_random_burst();
		test_range_error();
		test_back_pressure();

		$display("checks ok: %0d, errors: %0d", pass_count, err_count);
		if (err_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== boot_fetch.f ====
hdl/boot_fetch_pkg.sv
hdl/boot_rom.sv
hdl/fetch_addr_queue.sv
hdl/rom_bus_master.sv
hdl/line_out_buffer.sv
hdl/boot_fetch.sv
test/boot_fetch_tb.sv

// ==== Makefile ====
# verilator flow for the boot fetch subsystem, run from the project root

TOP = boot_fetch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f boot_fetch.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f boot_fetch.f --top-module $(TOP) -o boot_fetch_sim
	./obj_dir/boot_fetch_sim | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/boot_rom.mem ====
// one 128-bit line per row, row n is line n
// each 32-bit word holds b0, the line number, then the word number 3..0
b0000003b0000002b0000001b0000000
b0010003b0010002b0010001b0010000
b0020003b0020002b0020001b0020000
b0030003b0030002b0030001b0030000
b0040003b0040002b0040001b0040000
b0050003b0050002b0050001b0050000
b0060003b0060002b0060001b0060000
b0070003b0070002b0070001b0070000
b0080003b0080002b0080001b0080000
b0090003b0090002b0090001b0090000
b00a0003b00a0002b00a0001b00a0000
b00b0003b00b0002b00b0001b00b0000
b00c0003b00c0002b00c0001b00c0000
b00d0003b00d0002b00d0001b00d0000
b00e0003b00e0002b00e0001b00e0000
b00f0003b00f0002b00f0001b00f0000
b0100003b0100002b0100001b0100000
b0110003b0110002b0110001b0110000
b0120003b0120002b0120001b0120000
b0130003b0130002b0130001b0130000
b0140003b0140002b0140001b0140000
b0150003b0150002b0150001b0150000
b0160003b0160002b0160001b0160000
b0170003b0170002b0170001b0170000
b0180003b0180002b0180001b0180000
b0190003b0190002b0190001b0190000
b01a0003b01a0002b01a0001b01a0000
b01b0003b01b0002b01b0001b01b0000
b01c0003b01c0002b01c0001b01c0000
b01d0003b01d0002b01d0001b01d0000
b01e0003b01e0002b01e0001b01e0000
b01f0003b01f0002b01f0001b01f0000
